//--- design/decode_params.svh
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// instruction word and immediate
`define INST_W 32

// field widths inside the word
`define OPC_W 7
`define F3_W 3
`define F7_W 7
`define F12_W 12
`define REG_W 5

`define F7_ALT 7'b0100000          // sub / sra select
`define F12_EBREAK 12'h001
`define F12_ECALL 12'h000
`define F12_MRET 12'h302
`define MASK_W 8                   // byte lanes of a memory access

`endif

//--- design/decodePkg.sv
`include "decode_params.svh"

package decodePkg;

    // rv32i major opcodes
    typedef enum logic [6:0] {
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opBranch = 7'b1100011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opImm    = 7'b0010011,     // register-immediate arithmetic
        opOp     = 7'b0110011,     // register-register arithmetic
        opSystem = 7'b1110011      // ecall, ebreak, mret, csr*
    } opcode_t;

    typedef enum logic [2:0] {
        fmtI, fmtS, fmtR, fmtU, fmtJ, fmtB, fmtN
    } instFormat_t;

    typedef enum logic [2:0] {
        aluAdd, aluSub, aluSra, aluAnd, aluOr, aluXor, aluSll, aluSrl
    } aluOp_t;

    // where the destination register value comes from
    typedef enum logic [2:0] {
        rdAlu, rdMem, rdLink, rdCmp, rdCsr, rdNone
    } rdSrc_t;

    typedef enum logic [1:0] {
        srcReg, srcImm, srcCsr
    } aluSrc2_t;

    typedef enum logic [2:0] {
        cmpEq, cmpNe, cmpLt, cmpGe, cmpLtu, cmpGeu
    } cmpType_t;

    typedef enum logic [2:0] {
        memByte, memHalf, memWord, memByteU, memHalfU
    } memType_t;

    // raw fields sliced from the captured word, 61 bits
    typedef struct packed {
        logic [`OPC_W-1:0]  opcode;
        logic [`F3_W-1:0]   funct3;
        logic [`F7_W-1:0]   funct7;
        logic [`F12_W-1:0]  funct12;
        logic [`INST_W-1:0] word;
    } instFields_t;

    typedef struct packed {
        logic               memValid;
        logic               memWrite;
        logic [`MASK_W-1:0] memMask;
        memType_t           memType;   // load extension, don't care on stores
    } memCtrl_t;

    typedef struct packed {
        instFormat_t instFormat;
        memCtrl_t    memCtrl;
        cmpType_t    cmpType;
        logic        isBranch;
        logic        isJump;
        logic        isJalr;
        aluOp_t      aluOp;
        rdSrc_t      rdSrc;
        aluSrc2_t    aluSrc2;
        logic        isEcall;
        logic        isMret;
        logic        writeCsr;
    } decodeCtrl_t;

endpackage

//--- design/instCapture.sv
`include "decode_params.svh"

module instCapture (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   instValid,     // one-cycle strobe
    input  logic [`INST_W-1:0]     instWord,
    output decodePkg::instFields_t fields,
    output logic                   fieldsValid    // strobe delayed by one cycle
);

    logic [`INST_W-1:0] wordQ;     // captured instruction
    logic               validQ;

    // strobe pipeline, cleared by reset
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validQ <= 1'b0;
        end else begin
            validQ <= instValid;
        end
    end

    // word only loads on a strobe
    always_ff @(posedge clk) begin
        if (instValid) begin
            wordQ <= instWord;
        end
    end

    // standard rv32i field positions
    always_comb begin
        fields.opcode  = wordQ[6:0];
        fields.funct3  = wordQ[14:12];
        fields.funct7  = wordQ[31:25];
        fields.funct12 = wordQ[31:20];   // system code or csr address
        fields.word    = wordQ;          // immGen slices the rest
    end

    assign fieldsValid = validQ;

endmodule

//--- design/ctrlDecoder.sv
`include "decode_params.svh"

module ctrlDecoder (
    input  decodePkg::instFields_t fields,
    output decodePkg::decodeCtrl_t ctrl,
    output logic                   haltReq    // ebreak or illegal
);
    import decodePkg::*;

    logic isLui, isAuipc, isJal, isJalr, isBranch;
    logic isLoad, isStore, isImm, isOp, isSystem;
    logic sysF3Zero, isEbreak, isEcall, isMret;
    logic isIllegal;
    logic setLess;                   // slt, sltu, slti, sltiu
    logic altF7;

    // opcode classes
    assign isLui    = fields.opcode == opLui;
    assign isAuipc  = fields.opcode == opAuipc;
    assign isJal    = fields.opcode == opJal;
    assign isJalr   = (fields.opcode == opJalr) && (fields.funct3 == 3'd0);  // only funct3 0
    assign isBranch = fields.opcode == opBranch;
    assign isLoad   = fields.opcode == opLoad;
    assign isStore  = fields.opcode == opStore;
    assign isImm    = fields.opcode == opImm;
    assign isOp     = fields.opcode == opOp;
    assign isSystem = fields.opcode == opSystem;

    // system sub-decode by funct12
    assign sysF3Zero = isSystem && (fields.funct3 == 3'd0);
    assign isEbreak  = sysF3Zero && (fields.funct12 == `F12_EBREAK);
    assign isEcall   = sysF3Zero && (fields.funct12 == `F12_ECALL);
    assign isMret    = sysF3Zero && (fields.funct12 == `F12_MRET);

    // bad jalr funct3 falls out here too
    assign isIllegal = !(isLui | isAuipc | isJal | isJalr | isBranch |
                         isLoad | isStore | isImm | isOp | isSystem);
    assign haltReq   = isEbreak | isIllegal;

    assign setLess = (isImm | isOp) && (fields.funct3[2:1] == 2'b01);  // funct3 2 or 3
    assign altF7   = fields.funct7 == `F7_ALT;

    always_comb begin
        // format from opcode class
        case (1'b1)
            isLui, isAuipc:        ctrl.instFormat = fmtU;
            isJal:                 ctrl.instFormat = fmtJ;
            isJalr, isLoad, isImm: ctrl.instFormat = fmtI;
            isBranch:              ctrl.instFormat = fmtB;
            isStore:               ctrl.instFormat = fmtS;
            isOp:                  ctrl.instFormat = fmtR;
            default:               ctrl.instFormat = fmtN;
        endcase

        // memory side, zero unless load or store
        ctrl.memCtrl.memValid = isLoad | isStore;
        ctrl.memCtrl.memWrite = isStore;
        ctrl.memCtrl.memMask  = '0;
        ctrl.memCtrl.memType  = memByte;
        if (isLoad | isStore) begin
            case (fields.funct3)
                3'd0:    ctrl.memCtrl.memMask = 8'h01;
                3'd1:    ctrl.memCtrl.memMask = 8'h03;
                3'd2:    ctrl.memCtrl.memMask = 8'h0f;
                default: ctrl.memCtrl.memMask = 8'h00;   // lbu/lhu mask stays zero
            endcase
            case (fields.funct3)
                3'd1:    ctrl.memCtrl.memType = memHalf;
                3'd2:    ctrl.memCtrl.memType = memWord;
                3'd4:    ctrl.memCtrl.memType = memByteU;
                3'd5:    ctrl.memCtrl.memType = memHalfU;
                default: ctrl.memCtrl.memType = memByte;
            endcase
        end

        // compare type
        ctrl.cmpType = cmpEq;
        if (isBranch) begin
            case (fields.funct3)
                3'd1:    ctrl.cmpType = cmpNe;
                3'd4:    ctrl.cmpType = cmpLt;
                3'd5:    ctrl.cmpType = cmpGe;
                3'd6:    ctrl.cmpType = cmpLtu;
                3'd7:    ctrl.cmpType = cmpGeu;
                default: ctrl.cmpType = cmpEq;
            endcase
        end else if (setLess) begin
            ctrl.cmpType = fields.funct3[0] ? cmpLtu : cmpLt;
        end

        // alu op; compares run through the subtractor
        ctrl.aluOp = aluAdd;
        if (isBranch || setLess || (isOp && (fields.funct3 == 3'd0) && altF7)) begin
            ctrl.aluOp = aluSub;
        end else if (isImm || isOp) begin
            case (fields.funct3)
                3'd1:    ctrl.aluOp = aluSll;
                3'd4:    ctrl.aluOp = aluXor;
                3'd5:    ctrl.aluOp = altF7 ? aluSra : aluSrl;
                3'd6:    ctrl.aluOp = aluOr;
                3'd7:    ctrl.aluOp = aluAnd;
                default: ctrl.aluOp = aluAdd;
            endcase
        end

        // destination source, first match wins
        case (1'b1)
            isBranch, isStore, isEcall, isMret, isEbreak, isIllegal: ctrl.rdSrc = rdNone;
            isLoad:        ctrl.rdSrc = rdMem;
            isJal, isJalr: ctrl.rdSrc = rdLink;   // pc + 4
            setLess:       ctrl.rdSrc = rdCmp;
            isSystem:      ctrl.rdSrc = rdCsr;    // csrrw, csrrs and friends
            default:       ctrl.rdSrc = rdAlu;
        endcase

        if (isOp) begin
            ctrl.aluSrc2 = srcReg;
        end else if (isSystem) begin
            ctrl.aluSrc2 = srcCsr;
        end else begin
            ctrl.aluSrc2 = srcImm;
        end

        ctrl.isBranch = isBranch;
        ctrl.isJump   = isJal | isJalr;
        ctrl.isJalr   = isJalr;
        ctrl.isEcall  = isEcall;
        ctrl.isMret   = isMret;
        ctrl.writeCsr = isSystem & ~isEbreak & ~isMret;   // ecall writes mepc/mcause
    end

endmodule

//--- design/immGen.sv
`include "decode_params.svh"

module immGen (
    input  decodePkg::instFields_t fields,
    input  decodePkg::instFormat_t format,
    output logic [`INST_W-1:0]     imm
);
    import decodePkg::*;

    logic                sign;       // every immediate extends from bit 31
    logic [`REG_W-1:0]   rdField;    // low s/b bits sit in the rd slot
    logic [`INST_W-1:0]  w;

    assign w       = fields.word;
    assign sign    = w[31];
    assign rdField = w[11:7];

    always_comb begin
        case (format)
            fmtI: imm = {{20{sign}}, fields.funct12};
            fmtS: imm = {{20{sign}}, fields.funct7, rdField};
            fmtB: begin
                // bit 11 borrowed from rd[0], lsb always zero
                imm = {{20{sign}}, rdField[0], w[30:25], rdField[4:1], 1'b0};
            end
            fmtU: imm = {w[31:12], 12'b0};
            fmtJ: begin
                // scrambled 20-bit offset, halfword aligned
                imm = {{12{sign}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            default: imm = '0;               // r and n carry no immediate
        endcase
    end

endmodule

//--- design/decodeOutput.sv
`include "decode_params.svh"

module decodeOutput (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   fieldsValid,
    input  logic                   haltReq,
    input  decodePkg::decodeCtrl_t ctrlIn,
    input  logic [`INST_W-1:0]     immIn,
    output decodePkg::decodeCtrl_t ctrlOut,
    output logic [`INST_W-1:0]     immOut,
    output logic                   decodeValid,   // one pulse per accepted item
    output logic                   halted         // sticky until reset
);

    logic accept;

    // nothing passes once halted, nor the halting item itself
    assign accept = fieldsValid && !haltReq && !halted;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ctrlOut     <= '0;
            immOut      <= '0;
            decodeValid <= 1'b0;
            halted      <= 1'b0;
        end else begin
            decodeValid <= accept;
            if (accept) begin
                ctrlOut <= ctrlIn;      // outputs hold between items
                immOut  <= immIn;
            end
            if (fieldsValid && haltReq) begin
                halted <= 1'b1;         // only reset clears it
            end
        end
    end

endmodule

//--- design/decodeStage.sv
`include "decode_params.svh"

module decodeStage (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   instValid,
    input  logic [`INST_W-1:0]     instWord,
    output decodePkg::decodeCtrl_t ctrlOut,
    output logic [`INST_W-1:0]     immOut,
    output logic                   decodeValid,
    output logic                   halted
);
    import decodePkg::*;

    instFields_t        fields;
    logic               fieldsValid;
    decodeCtrl_t        ctrl;           // combinational decode result
    logic               haltReq;
    logic [`INST_W-1:0] imm;

    // cycle 1 capture
    instCapture capture0 (
        .clk         (clk),
        .rstN        (rstN),
        .instValid   (instValid),
        .instWord    (instWord),
        .fields      (fields),
        .fieldsValid (fieldsValid)
    );

    ctrlDecoder decoder0 (
        .fields  (fields),
        .ctrl    (ctrl),
        .haltReq (haltReq)
    );

    // immediate keyed by the decoded format
    immGen immGen0 (
        .fields (fields),
        .format (ctrl.instFormat),
        .imm    (imm)
    );

    // cycle 2 output register
    decodeOutput output0 (
        .clk         (clk),
        .rstN        (rstN),
        .fieldsValid (fieldsValid),
        .haltReq     (haltReq),
        .ctrlIn      (ctrl),
        .immIn       (imm),
        .ctrlOut     (ctrlOut),
        .immOut      (immOut),
        .decodeValid (decodeValid),
        .halted      (halted)
    );

endmodule

//--- verif/decodeStageTb.sv
`include "decode_params.svh"

module decodeStageTb;
    timeunit 1ns;
    timeprecision 1ps;
    import decodePkg::*;

    logic               clk;
    logic               rstN;
    logic               instValid;
    logic [`INST_W-1:0] instWord;
    decodeCtrl_t        ctrlOut;
    logic [`INST_W-1:0] immOut;
    logic               decodeValid;
    logic               halted;
    int                 errCount;
    int                 errMark;       // errors at start of current test
    int                 testCount;
    int                 lastEdges;     // edges from strobe to decodeValid

    // per-funct3 expectations
    localparam cmpType_t brCmpTable [8] = '{cmpEq, cmpNe, cmpEq, cmpEq,
                                             cmpLt, cmpGe, cmpLtu, cmpGeu};
    localparam aluOp_t aluTable [8] = '{aluAdd, aluSll, aluSub, aluSub,
                                         aluXor, aluSrl, aluOr, aluAnd};
    localparam logic [`MASK_W-1:0] maskTable [8] = '{8'h01, 8'h03, 8'h0f, 8'h00,
                                                     8'h00, 8'h00, 8'h00, 8'h00};
    localparam memType_t memTypeTable [8] = '{memByte, memHalf, memWord, memByte,
                                               memByteU, memHalfU, memByte, memByte};

    decodeStage dut0 (
        .clk         (clk),
        .rstN        (rstN),
        .instValid   (instValid),
        .instWord    (instWord),
        .ctrlOut     (ctrlOut),
        .immOut      (immOut),
        .decodeValid (decodeValid),
        .halted      (halted)
    );

    always #10 clk = ~clk;             // 20 ns period

    // reference decode of one word
    function automatic decodeCtrl_t expectCtrl(input logic [`INST_W-1:0] w);
        decodeCtrl_t c;
        logic [`F3_W-1:0] f3;
        logic             ebreak;
        f3 = w[14:12];
        c = '0;                        // eq, add, flags low
        c.instFormat = fmtN;
        c.rdSrc = rdAlu;
        c.aluSrc2 = srcImm;
        case (w[6:0])
            opLui, opAuipc: c.instFormat = fmtU;
            opJal: begin
                c.instFormat = fmtJ;
                c.isJump = 1'b1;
                c.rdSrc = rdLink;
            end
            opJalr: begin              // nonzero funct3 is illegal
                c.instFormat = (f3 == 3'd0) ? fmtI : fmtN;
                c.isJump = (f3 == 3'd0);
                c.isJalr = (f3 == 3'd0);
                c.rdSrc = (f3 == 3'd0) ? rdLink : rdNone;
            end
            opBranch: begin
                c.instFormat = fmtB;
                c.isBranch = 1'b1;
                c.aluOp = aluSub;
                c.cmpType = brCmpTable[f3];
                c.rdSrc = rdNone;
            end
            opLoad: begin
                c.instFormat = fmtI;
                c.memCtrl = '{1'b1, 1'b0, maskTable[f3], memTypeTable[f3]};
                c.rdSrc = rdMem;
            end
            opStore: begin
                c.instFormat = fmtS;
                c.memCtrl = '{1'b1, 1'b1, maskTable[f3], memTypeTable[f3]};
                c.rdSrc = rdNone;
            end
            opImm, opOp: begin
                c.instFormat = (w[6:0] == opOp) ? fmtR : fmtI;
                c.aluSrc2 = (w[6:0] == opOp) ? srcReg : srcImm;
                c.aluOp = aluTable[f3];
                if (f3 == 3'd5 && w[31:25] == `F7_ALT) c.aluOp = aluSra;
                if (f3 == 3'd0 && w[31:25] == `F7_ALT && w[6:0] == opOp) c.aluOp = aluSub;
                if (f3 == 3'd2 || f3 == 3'd3) begin    // slt family
                    c.cmpType = (f3 == 3'd3) ? cmpLtu : cmpLt;
                    c.rdSrc = rdCmp;
                end
            end
            opSystem: begin
                ebreak = (f3 == 3'd0) && (w[31:20] == `F12_EBREAK);
                c.isEcall = (f3 == 3'd0) && (w[31:20] == `F12_ECALL);
                c.isMret = (f3 == 3'd0) && (w[31:20] == `F12_MRET);
                c.aluSrc2 = srcCsr;
                c.writeCsr = !ebreak && !c.isMret;
                c.rdSrc = (ebreak || c.isEcall || c.isMret) ? rdNone : rdCsr;
            end
            default: c.rdSrc = rdNone;  // unknown opcode
        endcase
        return c;
    endfunction

    function automatic logic [`INST_W-1:0] expectImm(input logic [`INST_W-1:0] w);
        decodeCtrl_t        c;
        logic [`INST_W-1:0] sx;
        c = expectCtrl(w);
        sx = {`INST_W{w[31]}};
        case (c.instFormat)
            fmtI: return {sx[31:12], w[31:20]};
            fmtS: return {sx[31:12], w[31:25], w[11:7]};
            fmtB: return {sx[31:13], w[31], w[7], w[30:25], w[11:8], 1'b0};
            fmtU: return {w[31:12], 12'h000};
            fmtJ: return {sx[31:21], w[31], w[19:12], w[20], w[30:21], 1'b0};
            default: return '0;
        endcase
    endfunction

    // random regs and immediate bits around fixed opcode, funct3, funct7
    function automatic logic [`INST_W-1:0] mkWord(input logic [`OPC_W-1:0] op,
                                                  input logic [`F3_W-1:0] f3,
                                                  input logic [`F7_W-1:0] f7);
        logic [`INST_W-1:0] w;
        w = $urandom();
        w[6:0] = op;
        w[14:12] = f3;
        w[31:25] = f7;
        return w;
    endfunction

    task automatic checkCtrl(input decodeCtrl_t got, input decodeCtrl_t exp, input string what);
        if (got !== exp) begin
            $display("error at %0t: %s got %h expected %h", $time, what, got, exp);
            errCount++;
        end
    endtask

    task automatic checkImm(input logic [`INST_W-1:0] got, input logic [`INST_W-1:0] exp,
                            input string what);
        if (got !== exp) begin
            $display("error at %0t: %s got %h expected %h", $time, what, got, exp);
            errCount++;
        end
    endtask

    task automatic checkFlag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("error at %0t: %s got %b expected %b", $time, what, got, exp);
            errCount++;
        end
    endtask

    task automatic applyReset();
        rstN = 1'b0;
        instValid = 1'b0;
        repeat (16) @(posedge clk);
        #2 rstN = 1'b1;
    endtask

    // strobe one word, wait for its result and compare
    task automatic decodeOne(input logic [`INST_W-1:0] w);
        instWord = w;
        instValid = 1'b1;
        lastEdges = 0;
        do begin
            @(posedge clk);
            #2;                        // sample and drive point
            instValid = 1'b0;
            lastEdges++;
        end while (!decodeValid && lastEdges < 10);
        if (!decodeValid) begin
            $display("decodeValid never came within 10 cycles for word %h", w);
            errCount++;
        end else begin
            checkCtrl(ctrlOut, expectCtrl(w), $sformatf("ctrl of %h", w));
            checkImm(immOut, expectImm(w), $sformatf("imm of %h", w));
        end
    endtask

    task automatic expectNoValid(input logic [`INST_W-1:0] w);
        int n;
        instWord = w;
        instValid = 1'b1;
        for (n = 0; n < 4; n++) begin
            @(posedge clk);
            #2;
            instValid = 1'b0;
            checkFlag(decodeValid, 1'b0, "decodeValid while halting");
        end
    endtask

    task automatic reportTest(input string name);
        testCount++;
        $display("test %0d %s: %0d errors", testCount, name, errCount - errMark);
        errMark = errCount;
    endtask

    task automatic resetLatencyTest();
        checkFlag(decodeValid, 1'b0, "decodeValid after reset");
        checkFlag(halted, 1'b0, "halted after reset");
        checkCtrl(ctrlOut, '0, "ctrlOut after reset");
        checkImm(immOut, '0, "immOut after reset");
        decodeOne(mkWord(opImm, 3'd0, 7'($urandom())));    // addi
        checkFlag(lastEdges == 2, 1'b1, "two-edge latency");
    endtask

    task automatic arithTest();
        int f;
        for (f = 0; f < 8; f++) begin
            decodeOne(mkWord(opOp, 3'(f), 7'h00));
            decodeOne(mkWord(opImm, 3'(f), (f == 1 || f == 5) ? 7'h00 : 7'($urandom())));
        end
        decodeOne(mkWord(opOp, 3'd0, `F7_ALT));              // sub
        decodeOne(mkWord(opOp, 3'd5, `F7_ALT));              // sra
        decodeOne(mkWord(opImm, 3'd5, `F7_ALT));             // srai
    endtask

    task automatic memBranchTest();
        int f;
        int r;
        for (r = 0; r < 2; r++) begin                       // both sign bits
            for (f = 0; f < 8; f++) begin
                if (f != 3 && f < 6) decodeOne(mkWord(opLoad, 3'(f), {1'(r), 6'($urandom())}));
                if (f < 3) decodeOne(mkWord(opStore, 3'(f), {1'(r), 6'($urandom())}));
                if (f != 2 && f != 3) decodeOne(mkWord(opBranch, 3'(f), {1'(r), 6'($urandom())}));
            end
        end
    endtask

    task automatic jumpSysTest();
        int r;
        for (r = 0; r < 2; r++) begin
            decodeOne(mkWord(opJal, 3'($urandom()), {1'(r), 6'($urandom())}));
            decodeOne(mkWord(opJalr, 3'd0, {1'(r), 6'($urandom())}));
            decodeOne(mkWord(opLui, 3'($urandom()), {1'(r), 6'($urandom())}));
            decodeOne(mkWord(opAuipc, 3'($urandom()), {1'(r), 6'($urandom())}));
            decodeOne(mkWord(opSystem, 3'd1, {1'(r), 6'($urandom())}));    // csrrw
        end
        decodeOne(32'h0000_0073);      // ecall
        decodeOne(32'h3020_0073);      // mret
    endtask

    task automatic backToBackTest();
        logic [`INST_W-1:0] words [5];
        int sent;
        int got;
        int n;
        words = '{mkWord(opImm, 3'd4, 7'h00), mkWord(opLoad, 3'd2, 7'h15),
                  mkWord(opBranch, 3'd1, 7'h40), mkWord(opJal, 3'd3, 7'h2a),
                  mkWord(opOp, 3'd0, `F7_ALT)};
        sent = 0;
        got = 0;
        for (n = 0; n < 15 && got < 5; n++) begin
            instValid = sent < 5;      // one strobe per cycle
            if (sent < 5) instWord = words[sent];
            sent++;
            @(posedge clk);
            #2;
            if (decodeValid) begin
                checkCtrl(ctrlOut, expectCtrl(words[got]), "back-to-back ctrl");
                checkImm(immOut, expectImm(words[got]), "back-to-back imm");
                got++;
            end
        end
        instValid = 1'b0;
        if (got != 5) begin
            $display("only %0d of 5 back-to-back results came", got);
            errCount++;
        end
        @(posedge clk);
        #2 checkFlag(decodeValid, 1'b0, "extra decodeValid after burst");
    endtask

    task automatic haltTest();
        expectNoValid(mkWord(7'h7f, 3'($urandom()), 7'($urandom())));  // no such opcode
        checkFlag(halted, 1'b1, "halted after illegal");
        expectNoValid(mkWord(opImm, 3'd0, 7'h00));          // legal but blocked
        checkFlag(halted, 1'b1, "halted held");
        applyReset();
        checkFlag(halted, 1'b0, "halted after second reset");
        decodeOne(mkWord(opOp, 3'd7, 7'h00));
        expectNoValid(32'h0010_0073);  // ebreak
        checkFlag(halted, 1'b1, "halted after ebreak");
    endtask

    initial begin
        void'($urandom(32'hba69));
        clk = 1'b0;
        instWord = '0;
        errCount = 0;
        errMark = 0;
        testCount = 0;
        applyReset();
        resetLatencyTest();
        reportTest("reset and latency");
        arithTest();
        reportTest("arithmetic and compare");
        memBranchTest();
        reportTest("memory and branches");
        jumpSysTest();
        reportTest("jumps, upper immediates, system");
        backToBackTest();
        reportTest("back-to-back");
        haltTest();
        reportTest("halt");
        $display("%0d tests run, %0d errors", testCount, errCount);
        if (errCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- decodeStage.f
+incdir+design
design/decodePkg.sv
design/instCapture.sv
design/ctrlDecoder.sv
design/immGen.sv
design/decodeOutput.sv
design/decodeStage.sv
verif/decodeStageTb.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing --top-module decodeStageTb -f decodeStage.f -o decodeSim \
    > sim.log 2>&1 &&
    ./obj_dir/decodeSim >> sim.log 2>&1 ||
    echo "build or run failed" >> sim.log
grep -q "SIMULATION PASSED" sim.log && echo "run.sh: pass" ||
    { echo "run.sh: fail, see sim.log"; exit 1; }
